// File: design/qu_defs.svh
`ifndef QU_DEFS_SVH
`define QU_DEFS_SVH

// Operand and result width
`define QU_XLEN 32

// Destination tag width
`define QU_TAG_W 4

// Reservation station slots
`define QU_RS_DEPTH 4

// Entries in the FIFO between scheduler and execute
`define QU_FIFO_DEPTH 4

`endif

// File: design/qu_common_pkg.sv
`default_nettype none

`include "qu_defs.svh"

package qu_common_pkg;

    typedef logic [`QU_XLEN-1:0] word_t;                  // Operand or result
    typedef logic [`QU_TAG_W-1:0] tag_t;                  // Destination tag
    typedef logic [$clog2(`QU_RS_DEPTH)-1:0] rs_addr_t;   // Station slot index

endpackage

`default_nettype wire

// File: design/qu_uop_pkg.sv
`default_nettype none

`include "qu_defs.svh"

package qu_uop_pkg;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_SRL = 3'd6,
        OP_SLT = 3'd7
    } opcode_t;

    // Packed layout, MSB first: opcode, src1, src2, tag
    localparam int OPCODE_W = $bits(opcode_t);
    localparam int UOP_TAG_LSB = 0;
    localparam int UOP_SRC2_LSB = UOP_TAG_LSB + `QU_TAG_W;
    localparam int UOP_SRC1_LSB = UOP_SRC2_LSB + `QU_XLEN;
    localparam int UOP_OP_LSB = UOP_SRC1_LSB + `QU_XLEN;
    localparam int UOP_W = UOP_OP_LSB + OPCODE_W;          // 71 bits

endpackage

`default_nettype wire

// File: design/qu_res_station.sv
`timescale 1ns/1ns
`default_nettype none

`include "qu_defs.svh"

module qu_res_station (
    input  logic                       clk,
    input  logic                       reset,

    input  logic                       dispatch_valid,
    input  qu_uop_pkg::opcode_t        dispatch_opcode,
    input  qu_common_pkg::word_t       dispatch_src1,
    input  qu_common_pkg::word_t       dispatch_src2,
    input  qu_common_pkg::tag_t        dispatch_tag,
    output logic                       dispatch_ready,

    input  qu_common_pkg::rs_addr_t    rd1_addr,
    input  qu_common_pkg::rs_addr_t    rd2_addr,
    input  qu_common_pkg::rs_addr_t    rd3_addr,
    input  qu_common_pkg::rs_addr_t    rd4_addr,
    output logic                       rd1_valid,
    output logic                       rd2_valid,
    output logic                       rd3_valid,
    output logic                       rd4_valid,
    output qu_uop_pkg::opcode_t        rd1_opcode,
    output qu_uop_pkg::opcode_t        rd2_opcode,
    output qu_uop_pkg::opcode_t        rd3_opcode,
    output qu_uop_pkg::opcode_t        rd4_opcode,
    output qu_common_pkg::word_t       rd1_src1,
    output qu_common_pkg::word_t       rd2_src1,
    output qu_common_pkg::word_t       rd3_src1,
    output qu_common_pkg::word_t       rd4_src1,
    output qu_common_pkg::word_t       rd1_src2,
    output qu_common_pkg::word_t       rd2_src2,
    output qu_common_pkg::word_t       rd3_src2,
    output qu_common_pkg::word_t       rd4_src2,
    output qu_common_pkg::tag_t        rd1_tag,
    output qu_common_pkg::tag_t        rd2_tag,
    output qu_common_pkg::tag_t        rd3_tag,
    output qu_common_pkg::tag_t        rd4_tag,

    input  logic                       issue_clear,
    input  qu_common_pkg::rs_addr_t    issue_addr
);

    logic [`QU_RS_DEPTH-1:0] slot_valid;
    qu_uop_pkg::opcode_t     slot_opcode [`QU_RS_DEPTH];
    qu_common_pkg::word_t    slot_src1 [`QU_RS_DEPTH];
    qu_common_pkg::word_t    slot_src2 [`QU_RS_DEPTH];
    qu_common_pkg::tag_t     slot_tag [`QU_RS_DEPTH];
    qu_common_pkg::rs_addr_t free_addr;
    logic                    dispatch_fire;

    // Lowest-numbered free slot wins
    always_comb begin
        free_addr = '0;
        for (int i = `QU_RS_DEPTH - 1; i >= 0; i--) begin
            if (!slot_valid[i]) free_addr = qu_common_pkg::rs_addr_t'(i);
        end
    end

    assign dispatch_ready = ~&slot_valid;
    assign dispatch_fire = dispatch_valid & dispatch_ready;

    // Issued slot is valid and the free slot is not, so they never collide
    always_ff @(posedge clk) begin
        if (reset) begin
            slot_valid <= '0;
        end else begin
            if (issue_clear) slot_valid[issue_addr] <= 1'b0;
            if (dispatch_fire) slot_valid[free_addr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_fire) begin
            slot_opcode[free_addr] <= dispatch_opcode;
            slot_src1[free_addr] <= dispatch_src1;
            slot_src2[free_addr] <= dispatch_src2;
            slot_tag[free_addr] <= dispatch_tag;
        end
    end

    assign rd1_valid = slot_valid[rd1_addr];
    assign rd2_valid = slot_valid[rd2_addr];
    assign rd3_valid = slot_valid[rd3_addr];
    assign rd4_valid = slot_valid[rd4_addr];
    assign rd1_opcode = slot_opcode[rd1_addr];
    assign rd2_opcode = slot_opcode[rd2_addr];
    assign rd3_opcode = slot_opcode[rd3_addr];
    assign rd4_opcode = slot_opcode[rd4_addr];
    assign rd1_src1 = slot_src1[rd1_addr];
    assign rd2_src1 = slot_src1[rd2_addr];
    assign rd3_src1 = slot_src1[rd3_addr];
    assign rd4_src1 = slot_src1[rd4_addr];
    assign rd1_src2 = slot_src2[rd1_addr];
    assign rd2_src2 = slot_src2[rd2_addr];
    assign rd3_src2 = slot_src2[rd3_addr];
    assign rd4_src2 = slot_src2[rd4_addr];
    assign rd1_tag = slot_tag[rd1_addr];
    assign rd2_tag = slot_tag[rd2_addr];
    assign rd3_tag = slot_tag[rd3_addr];
    assign rd4_tag = slot_tag[rd4_addr];

endmodule

`default_nettype wire

// File: design/qu_schedule.sv
`timescale 1ns/1ns
`default_nettype none

module qu_schedule (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          en,

    output qu_common_pkg::rs_addr_t       rd1_addr,
    output qu_common_pkg::rs_addr_t       rd2_addr,
    output qu_common_pkg::rs_addr_t       rd3_addr,
    output qu_common_pkg::rs_addr_t       rd4_addr,
    input  logic                          rd1_valid,
    input  logic                          rd2_valid,
    input  logic                          rd3_valid,
    input  logic                          rd4_valid,
    input  qu_uop_pkg::opcode_t           rd1_opcode,
    input  qu_uop_pkg::opcode_t           rd2_opcode,
    input  qu_uop_pkg::opcode_t           rd3_opcode,
    input  qu_uop_pkg::opcode_t           rd4_opcode,
    input  qu_common_pkg::word_t          rd1_src1,
    input  qu_common_pkg::word_t          rd2_src1,
    input  qu_common_pkg::word_t          rd3_src1,
    input  qu_common_pkg::word_t          rd4_src1,
    input  qu_common_pkg::word_t          rd1_src2,
    input  qu_common_pkg::word_t          rd2_src2,
    input  qu_common_pkg::word_t          rd3_src2,
    input  qu_common_pkg::word_t          rd4_src2,
    input  qu_common_pkg::tag_t           rd1_tag,
    input  qu_common_pkg::tag_t           rd2_tag,
    input  qu_common_pkg::tag_t           rd3_tag,
    input  qu_common_pkg::tag_t           rd4_tag,

    input  logic                          fifo_full,
    output logic                          issue_clear,
    output qu_common_pkg::rs_addr_t       issue_addr,
    output logic                          fifo_wr_en,
    output logic [qu_uop_pkg::UOP_W-1:0]  fifo_data
);

    qu_common_pkg::rs_addr_t prio_ptr;
    logic                    sel_valid;
    qu_common_pkg::rs_addr_t sel_addr;
    qu_uop_pkg::opcode_t     sel_opcode;
    qu_common_pkg::word_t    sel_src1;
    qu_common_pkg::word_t    sel_src2;
    qu_common_pkg::tag_t     sel_tag;
    logic                    issue;

    // Port 1 looks at the pointer, the others follow with wrap
    assign rd1_addr = prio_ptr;
    assign rd2_addr = prio_ptr + qu_common_pkg::rs_addr_t'(1);
    assign rd3_addr = prio_ptr + qu_common_pkg::rs_addr_t'(2);
    assign rd4_addr = prio_ptr + qu_common_pkg::rs_addr_t'(3);

    always_comb begin
        sel_valid = 1'b1;
        sel_addr = rd1_addr;
        sel_opcode = rd1_opcode;
        sel_src1 = rd1_src1;
        sel_src2 = rd1_src2;
        sel_tag = rd1_tag;
        if (rd1_valid) begin
            sel_addr = rd1_addr;
        end else if (rd2_valid) begin
            sel_addr = rd2_addr;
            sel_opcode = rd2_opcode;
            sel_src1 = rd2_src1;
            sel_src2 = rd2_src2;
            sel_tag = rd2_tag;
        end else if (rd3_valid) begin
            sel_addr = rd3_addr;
            sel_opcode = rd3_opcode;
            sel_src1 = rd3_src1;
            sel_src2 = rd3_src2;
            sel_tag = rd3_tag;
        end else if (rd4_valid) begin
            sel_addr = rd4_addr;
            sel_opcode = rd4_opcode;
            sel_src1 = rd4_src1;
            sel_src2 = rd4_src2;
            sel_tag = rd4_tag;
        end else begin
            sel_valid = 1'b0;                   // Station empty
        end
    end

    assign issue = en & ~fifo_full & sel_valid;

    assign issue_clear = issue;
    assign issue_addr = sel_addr;
    assign fifo_wr_en = issue;
    assign fifo_data = {sel_opcode, sel_src1, sel_src2, sel_tag};

    // Slot after the issued one gets top priority next, so none starves
    always_ff @(posedge clk) begin
        if (reset) begin
            prio_ptr <= '0;
        end else if (issue) begin
            prio_ptr <= sel_addr + qu_common_pkg::rs_addr_t'(1);
        end
    end

endmodule

`default_nettype wire

// File: design/qu_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module qu_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] data_in,
    input  logic             rd_en,
    output logic [WIDTH-1:0] data_out,
    output logic             empty,
    output logic             full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign empty = (count == '0);
    assign full = (count == CNT_W'(DEPTH));
    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    assign data_out = mem[rd_ptr];              // Show-ahead head

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= data_in;
    end

endmodule

`default_nettype wire

// File: design/qu_execute.sv
`timescale 1ns/1ns
`default_nettype none

module qu_execute (
    input  logic [qu_uop_pkg::UOP_W-1:0] uop,
    output qu_common_pkg::word_t         value,
    output qu_common_pkg::tag_t          tag
);

    qu_uop_pkg::opcode_t  opcode;
    qu_common_pkg::word_t src1;
    qu_common_pkg::word_t src2;
    logic [4:0]           shamt;

    assign opcode = qu_uop_pkg::opcode_t'(uop[qu_uop_pkg::UOP_OP_LSB +: qu_uop_pkg::OPCODE_W]);
    assign src1 = uop[qu_uop_pkg::UOP_SRC1_LSB +: $bits(qu_common_pkg::word_t)];
    assign src2 = uop[qu_uop_pkg::UOP_SRC2_LSB +: $bits(qu_common_pkg::word_t)];
    assign tag = uop[qu_uop_pkg::UOP_TAG_LSB +: $bits(qu_common_pkg::tag_t)];
    assign shamt = src2[4:0];                   // Upper bits ignored

    always_comb begin
        case (opcode)
            qu_uop_pkg::OP_ADD: value = src1 + src2;
            qu_uop_pkg::OP_SUB: value = src1 - src2;
            qu_uop_pkg::OP_AND: value = src1 & src2;
            qu_uop_pkg::OP_OR:  value = src1 | src2;
            qu_uop_pkg::OP_XOR: value = src1 ^ src2;
            qu_uop_pkg::OP_SLL: value = src1 << shamt;
            qu_uop_pkg::OP_SRL: value = src1 >> shamt;
            qu_uop_pkg::OP_SLT: begin
                value = '0;
                value[0] = ($signed(src1) < $signed(src2));
            end
            default: value = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/qu_result.sv
`timescale 1ns/1ns
`default_nettype none

module qu_result (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 capture,
    input  qu_common_pkg::word_t value_in,
    input  qu_common_pkg::tag_t  tag_in,
    output logic                 result_valid,
    output qu_common_pkg::word_t result_value,
    output qu_common_pkg::tag_t  result_tag
);

    // One pulse per pop
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= capture;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            result_value <= value_in;
            result_tag <= tag_in;
        end
    end

endmodule

`default_nettype wire

// File: design/qu_back_end.sv
`timescale 1ns/1ns
`default_nettype none

`include "qu_defs.svh"

module qu_back_end (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 schedule_en,

    input  logic                 dispatch_valid,
    input  qu_uop_pkg::opcode_t  dispatch_opcode,
    input  qu_common_pkg::word_t dispatch_src1,
    input  qu_common_pkg::word_t dispatch_src2,
    input  qu_common_pkg::tag_t  dispatch_tag,
    output logic                 dispatch_ready,

    output logic                 result_valid,
    output qu_common_pkg::word_t result_value,
    output qu_common_pkg::tag_t  result_tag
);

    qu_common_pkg::rs_addr_t     rd1_addr, rd2_addr, rd3_addr, rd4_addr;
    logic                        rd1_valid, rd2_valid, rd3_valid, rd4_valid;
    qu_uop_pkg::opcode_t         rd1_opcode, rd2_opcode, rd3_opcode, rd4_opcode;
    qu_common_pkg::word_t        rd1_src1, rd2_src1, rd3_src1, rd4_src1;
    qu_common_pkg::word_t        rd1_src2, rd2_src2, rd3_src2, rd4_src2;
    qu_common_pkg::tag_t         rd1_tag, rd2_tag, rd3_tag, rd4_tag;

    logic                        issue_clear;
    qu_common_pkg::rs_addr_t     issue_addr;
    logic                        fifo_wr_en;
    logic [qu_uop_pkg::UOP_W-1:0] fifo_wr_data;
    logic [qu_uop_pkg::UOP_W-1:0] fifo_head;
    logic                        fifo_empty;
    logic                        fifo_full;
    logic                        fifo_rd_en;
    qu_common_pkg::word_t        exec_value;
    qu_common_pkg::tag_t         exec_tag;

    assign fifo_rd_en = ~fifo_empty;            // Pop whenever data is present

    qu_res_station u_res_station (
        .clk(clk), .reset(reset),
        .dispatch_valid(dispatch_valid), .dispatch_opcode(dispatch_opcode),
        .dispatch_src1(dispatch_src1), .dispatch_src2(dispatch_src2),
        .dispatch_tag(dispatch_tag), .dispatch_ready(dispatch_ready),
        .rd1_addr(rd1_addr), .rd2_addr(rd2_addr), .rd3_addr(rd3_addr), .rd4_addr(rd4_addr),
        .rd1_valid(rd1_valid), .rd2_valid(rd2_valid),
        .rd3_valid(rd3_valid), .rd4_valid(rd4_valid),
        .rd1_opcode(rd1_opcode), .rd2_opcode(rd2_opcode),
        .rd3_opcode(rd3_opcode), .rd4_opcode(rd4_opcode),
        .rd1_src1(rd1_src1), .rd2_src1(rd2_src1), .rd3_src1(rd3_src1), .rd4_src1(rd4_src1),
        .rd1_src2(rd1_src2), .rd2_src2(rd2_src2), .rd3_src2(rd3_src2), .rd4_src2(rd4_src2),
        .rd1_tag(rd1_tag), .rd2_tag(rd2_tag), .rd3_tag(rd3_tag), .rd4_tag(rd4_tag),
        .issue_clear(issue_clear), .issue_addr(issue_addr)
    );

    qu_schedule u_schedule (
        .clk(clk), .reset(reset), .en(schedule_en),
        .rd1_addr(rd1_addr), .rd2_addr(rd2_addr), .rd3_addr(rd3_addr), .rd4_addr(rd4_addr),
        .rd1_valid(rd1_valid), .rd2_valid(rd2_valid),
        .rd3_valid(rd3_valid), .rd4_valid(rd4_valid),
        .rd1_opcode(rd1_opcode), .rd2_opcode(rd2_opcode),
        .rd3_opcode(rd3_opcode), .rd4_opcode(rd4_opcode),
        .rd1_src1(rd1_src1), .rd2_src1(rd2_src1), .rd3_src1(rd3_src1), .rd4_src1(rd4_src1),
        .rd1_src2(rd1_src2), .rd2_src2(rd2_src2), .rd3_src2(rd3_src2), .rd4_src2(rd4_src2),
        .rd1_tag(rd1_tag), .rd2_tag(rd2_tag), .rd3_tag(rd3_tag), .rd4_tag(rd4_tag),
        .fifo_full(fifo_full),
        .issue_clear(issue_clear), .issue_addr(issue_addr),
        .fifo_wr_en(fifo_wr_en), .fifo_data(fifo_wr_data)
    );

    qu_fifo #(
        .WIDTH(qu_uop_pkg::UOP_W),
        .DEPTH(`QU_FIFO_DEPTH)
    ) u_fifo (
        .clk(clk), .reset(reset),
        .wr_en(fifo_wr_en), .data_in(fifo_wr_data),
        .rd_en(fifo_rd_en), .data_out(fifo_head),
        .empty(fifo_empty), .full(fifo_full)
    );

    qu_execute u_execute (
        .uop(fifo_head),
        .value(exec_value),
        .tag(exec_tag)
    );

    qu_result u_result (
        .clk(clk), .reset(reset),
        .capture(fifo_rd_en),
        .value_in(exec_value), .tag_in(exec_tag),
        .result_valid(result_valid),
        .result_value(result_value),
        .result_tag(result_tag)
    );

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 100                  // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: tb/qu_back_end_asserts.sv
`timescale 1ns/1ns
`default_nettype none

`include "qu_defs.svh"

module qu_back_end_asserts (
    input logic clk,
    input logic reset,
    input logic fifo_wr_en,
    input logic fifo_rd_en,
    input logic dispatch_ready,
    input logic rd1_valid,
    input logic rd2_valid,
    input logic rd3_valid,
    input logic rd4_valid,
    input logic result_valid
);

    int fifo_level;                             // Entries pushed and not yet popped

    always_ff @(posedge clk) begin
        if (reset) begin
            fifo_level <= 0;
        end else begin
            fifo_level <= fifo_level + int'(fifo_wr_en) - int'(fifo_rd_en);
        end
    end

    fifo_no_overflow: assert property (@(posedge clk) disable iff (reset)
        fifo_wr_en |-> (fifo_level < `QU_FIFO_DEPTH)) else $error("FIFO written while full");

    fifo_no_underflow: assert property (@(posedge clk) disable iff (reset)
        fifo_rd_en |-> (fifo_level != 0)) else $error("FIFO read while empty");

    // The four read ports cover all slots, pointer plus 0 to 3
    ready_low_only_when_full: assert property (@(posedge clk) disable iff (reset)
        !dispatch_ready |-> (rd1_valid && rd2_valid && rd3_valid && rd4_valid))
        else $error("dispatch_ready low with a free station slot");

    result_valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(result_valid)) else $error("result_valid is unknown");

endmodule

bind qu_back_end qu_back_end_asserts u_asserts (
    .clk(clk), .reset(reset),
    .fifo_wr_en(fifo_wr_en),
    .fifo_rd_en(fifo_rd_en),
    .dispatch_ready(dispatch_ready),
    .rd1_valid(rd1_valid), .rd2_valid(rd2_valid),
    .rd3_valid(rd3_valid), .rd4_valid(rd4_valid),
    .result_valid(result_valid)
);

`default_nettype wire

// File: tb/qu_back_end_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "qu_defs.svh"

module qu_back_end_tb;

    localparam int TABLE_LEN = 16;
    localparam int HOLD_LEN = 4;
    localparam int RAND_LEN = 32;
    localparam int NUM_TAGS = 2 ** `QU_TAG_W;
    localparam int CYCLE_LIMIT = 10 * (TABLE_LEN + HOLD_LEN + RAND_LEN) + 100;

    logic                 clk;
    logic                 reset;
    logic                 schedule_en;
    logic                 dispatch_valid;
    qu_uop_pkg::opcode_t  dispatch_opcode;
    qu_common_pkg::word_t dispatch_src1;
    qu_common_pkg::word_t dispatch_src2;
    qu_common_pkg::tag_t  dispatch_tag;
    logic                 dispatch_ready;
    logic                 result_valid;
    qu_common_pkg::word_t result_value;
    qu_common_pkg::tag_t  result_tag;

    qu_uop_pkg::opcode_t  tbl_op [TABLE_LEN];
    qu_common_pkg::word_t tbl_src1 [TABLE_LEN];
    qu_common_pkg::word_t tbl_src2 [TABLE_LEN];
    qu_common_pkg::word_t tbl_exp [TABLE_LEN];

    qu_common_pkg::word_t expected [NUM_TAGS];
    string                tag_name [NUM_TAGS];
    int                   sent_cnt [NUM_TAGS];  // Per tag, main flow only
    int                   back_cnt [NUM_TAGS];  // Per tag, monitor only
    int                   dispatched = 0;
    int                   returned = 0;
    int                   cycles = 0;
    integer               seed;
    logic                 quiet;                // No result may arrive
    logic                 toggle_sched;

    tb_clock_gen #(.PERIOD(100)) u_clock (.clk(clk));

    qu_back_end DUT (
        .clk(clk), .reset(reset), .schedule_en(schedule_en),
        .dispatch_valid(dispatch_valid), .dispatch_opcode(dispatch_opcode),
        .dispatch_src1(dispatch_src1), .dispatch_src2(dispatch_src2),
        .dispatch_tag(dispatch_tag), .dispatch_ready(dispatch_ready),
        .result_valid(result_valid), .result_value(result_value), .result_tag(result_tag)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            fail_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
        end
    endtask

    function automatic qu_common_pkg::word_t alu_model(input qu_uop_pkg::opcode_t op,
            input qu_common_pkg::word_t a, input qu_common_pkg::word_t b);
        qu_common_pkg::word_t r;
        r = '0;
        case (op)
            qu_uop_pkg::OP_ADD: r = a + b;
            qu_uop_pkg::OP_SUB: r = a + ~b + 32'd1;     // Two's complement
            qu_uop_pkg::OP_AND: r = a & b;
            qu_uop_pkg::OP_OR:  r = a | b;
            qu_uop_pkg::OP_XOR: r = a ^ b;
            qu_uop_pkg::OP_SLL: r = a << b[4:0];
            qu_uop_pkg::OP_SRL: r = a >> b[4:0];
            qu_uop_pkg::OP_SLT: begin
                if (a[31] != b[31]) r = {31'd0, a[31]};  // Negative one is smaller
                else r = {31'd0, a < b};
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic set_row(input int i, input qu_uop_pkg::opcode_t op,
                           input logic [31:0] a, input logic [31:0] b, input logic [31:0] e);
        tbl_op[i] = op;
        tbl_src1[i] = a;
        tbl_src2[i] = b;
        tbl_exp[i] = e;
    endtask

    task automatic load_table();
        set_row(0,  qu_uop_pkg::OP_ADD, 32'hFFFFFFFF, 32'h00000002, 32'h00000001);
        set_row(1,  qu_uop_pkg::OP_ADD, 32'h12345678, 32'h11111111, 32'h23456789);
        set_row(2,  qu_uop_pkg::OP_SUB, 32'h00000003, 32'h00000005, 32'hFFFFFFFE);
        set_row(3,  qu_uop_pkg::OP_SUB, 32'h80000000, 32'h00000001, 32'h7FFFFFFF);
        set_row(4,  qu_uop_pkg::OP_AND, 32'hF0F0F0F0, 32'h0FF00FF0, 32'h00F000F0);
        set_row(5,  qu_uop_pkg::OP_OR,  32'hF0000000, 32'h0000000F, 32'hF000000F);
        set_row(6,  qu_uop_pkg::OP_XOR, 32'hAAAA5555, 32'hFFFF0000, 32'h55555555);
        set_row(7,  qu_uop_pkg::OP_SLL, 32'h00000001, 32'hFFFFFFE0, 32'h00000001);
        set_row(8,  qu_uop_pkg::OP_SLL, 32'h00000001, 32'h0000003F, 32'h80000000);
        set_row(9,  qu_uop_pkg::OP_SRL, 32'h80000000, 32'hFFFFFFFF, 32'h00000001);
        set_row(10, qu_uop_pkg::OP_SRL, 32'hDEADBEEF, 32'h00000100, 32'hDEADBEEF);
        set_row(11, qu_uop_pkg::OP_SRL, 32'hF0000000, 32'h00000004, 32'h0F000000);
        set_row(12, qu_uop_pkg::OP_SLT, 32'hFFFFFFFF, 32'h00000001, 32'h00000001);
        set_row(13, qu_uop_pkg::OP_SLT, 32'h00000001, 32'hFFFFFFFF, 32'h00000000);
        set_row(14, qu_uop_pkg::OP_SLT, 32'h80000000, 32'h7FFFFFFF, 32'h00000001);
        set_row(15, qu_uop_pkg::OP_SLT, 32'h00000005, 32'h00000005, 32'h00000000);
    endtask

    // One clock, with a fresh random schedule_en in the random phase
    task automatic step_cycle();
        logic [31:0] rand_word;
        @(posedge clk);
        if (toggle_sched) begin
            rand_word = $random(seed);
            schedule_en <= rand_word[0];
        end
    endtask

    // Holds the micro-op until an edge where dispatch_ready was high
    task automatic dispatch_uop(input string name, input qu_uop_pkg::opcode_t op,
            input qu_common_pkg::word_t a, input qu_common_pkg::word_t b,
            input qu_common_pkg::tag_t tag, input qu_common_pkg::word_t exp);
        logic accepted;
        while (sent_cnt[tag] != back_cnt[tag]) begin
            dispatch_valid <= 1'b0;             // Tag still in flight
            step_cycle();
        end
        expected[tag] = exp;
        tag_name[tag] = name;
        sent_cnt[tag] = sent_cnt[tag] + 1;
        dispatch_valid <= 1'b1;
        dispatch_opcode <= op;
        dispatch_src1 <= a;
        dispatch_src2 <= b;
        dispatch_tag <= tag;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = dispatch_ready;
            step_cycle();
        end
        dispatched = dispatched + 1;
    endtask

    task automatic drain_all();
        dispatch_valid <= 1'b0;
        while (returned != dispatched) step_cycle();
    endtask

    // Result monitor
    always @(negedge clk) begin
        if (!reset && result_valid) begin
            if (quiet) begin
                fail_run("A result arrived while schedule_en was held low");
            end else if (sent_cnt[result_tag] == back_cnt[result_tag]) begin
                fail_run($sformatf("A result arrived with tag %0d, which was not outstanding",
                                   result_tag));
            end else begin
                check_value(tag_name[result_tag], expected[result_tag], result_value);
                back_cnt[result_tag] = back_cnt[result_tag] + 1;
                returned = returned + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            fail_run($sformatf("Timeout after %0d cycles with %0d of %0d results back",
                               cycles, returned, dispatched));
        end
    end

    initial begin
        logic [31:0]         rand_op;
        logic [31:0]         rand_a;
        logic [31:0]         rand_b;
        qu_uop_pkg::opcode_t op;
        seed = 32'h31b6d8c6;
        reset = 1'b1;
        schedule_en = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_opcode = qu_uop_pkg::OP_ADD;
        dispatch_src1 = '0;
        dispatch_src2 = '0;
        dispatch_tag = '0;
        quiet = 1'b0;
        toggle_sched = 1'b0;
        load_table();

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("dispatch_ready after reset", 32'd1, {31'd0, dispatch_ready});
        check_value("result_valid after reset", 32'd0, {31'd0, result_valid});
        @(posedge clk);

        for (int i = 0; i < TABLE_LEN; i++) begin
            dispatch_uop($sformatf("table row %0d", i), tbl_op[i], tbl_src1[i], tbl_src2[i],
                         qu_common_pkg::tag_t'(i), tbl_exp[i]);
        end
        drain_all();

        // Station fills up while nothing is issued
        schedule_en <= 1'b0;
        quiet = 1'b1;
        for (int i = 0; i < HOLD_LEN; i++) begin
            dispatch_uop($sformatf("held op %0d", i), qu_uop_pkg::OP_ADD, 32'h100 * i,
                         32'h7, qu_common_pkg::tag_t'(i), 32'h100 * i + 32'h7);
        end
        dispatch_valid <= 1'b0;
        @(negedge clk);
        check_value("dispatch_ready with a full station", 32'd0, {31'd0, dispatch_ready});
        repeat (4) step_cycle();
        quiet = 1'b0;
        schedule_en <= 1'b1;
        drain_all();

        toggle_sched = 1'b1;
        for (int k = 0; k < RAND_LEN; k++) begin
            rand_op = $random(seed);
            rand_a = $random(seed);
            rand_b = $random(seed);
            op = qu_uop_pkg::opcode_t'(rand_op[2:0]);
            dispatch_uop($sformatf("random op %0d", k), op, rand_a, rand_b,
                         qu_common_pkg::tag_t'(k % NUM_TAGS), alu_model(op, rand_a, rand_b));
        end
        drain_all();
        toggle_sched = 1'b0;

        repeat (4) step_cycle();                // Extra pulses after the drain hit the monitor
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+design
design/qu_common_pkg.sv
design/qu_uop_pkg.sv
design/qu_res_station.sv
design/qu_schedule.sv
design/qu_fifo.sv
design/qu_execute.sv
design/qu_result.sv
design/qu_back_end.sv
tb/tb_clock_gen.sv
tb/qu_back_end_asserts.sv
tb/qu_back_end_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the back end testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f filelist.f --top-module qu_back_end_tb -o qu_back_end_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/qu_back_end_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished with status 0"
exit 0
